// File: logic/dotmatrix_pkg.sv
package dotmatrix_pkg;

    // picture number shown on the matrix
    typedef logic [3:0] frame_id_t;

    // balloon sizes, one per pump
    localparam frame_id_t FRAME_BALLOON_0 = 4'd0;
    localparam frame_id_t FRAME_BALLOON_1 = 4'd1;
    localparam frame_id_t FRAME_BALLOON_2 = 4'd2;
    localparam frame_id_t FRAME_BALLOON_3 = 4'd3;
    localparam frame_id_t FRAME_BALLOON_4 = 4'd4;
    localparam frame_id_t FRAME_BALLOON_5 = 4'd5;

    localparam frame_id_t FRAME_BURST  = 4'd8;  // popped face
    localparam frame_id_t FRAME_TROPHY = 4'd11; // banked round

    // largest balloon frame, also the cap on the pump limit
    localparam int unsigned MAX_PUMPS = 5;

    typedef logic [2:0] row_idx_t;

    // one row of one colour, bit 7 is the leftmost column
    typedef logic [7:0] pixel_byte_t;

    // raw bitmap bytes for one row
    typedef struct packed
    {
        pixel_byte_t green;
        pixel_byte_t red;
    } row_pixels_t;

    // game controller to scanner
    typedef struct packed
    {
        logic      run;   // display enabled
        logic      warn;  // count sits at the limit
        frame_id_t frame;
    } game_view_t;

endpackage

// File: logic/scan_timer.sv
`timescale 1ns/1ps

module scan_timer #(
    parameter int unsigned SCAN_DIV = 1000
) (
    input  logic clk,
    input  logic rst,
    output logic step_tick
);

    localparam int unsigned CNT_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(SCAN_DIV - 1);

    logic [CNT_W-1:0] cnt;

    // counts RELOAD down to 0, so one tick every SCAN_DIV cycles
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt       <= RELOAD;
            step_tick <= 1'b0;
        end
        else
        begin
            if (cnt == '0)
            begin
                cnt       <= RELOAD;
                step_tick <= 1'b1;
            end
            else
            begin
                cnt       <= cnt - 1'b1;
                step_tick <= 1'b0;
            end
        end
    end

endmodule

// File: logic/balloon_game.sv
`timescale 1ns/1ps

module balloon_game (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      st,
    input  logic                      pump,
    input  logic                      bank,
    input  logic [2:0]                limit,
    output dotmatrix_pkg::game_view_t view
);

    typedef enum logic [1:0]
    {
        S_IDLE,
        S_PLAY,
        S_BURST,
        S_WON
    } state_t;

    localparam logic [2:0] LIM_MAX = 3'(dotmatrix_pkg::MAX_PUMPS);

    state_t     state;
    logic [2:0] count;   // pumps so far this round
    logic [2:0] lim;     // clamped limit, held for the round
    logic [2:0] lim_in;

    // switches above the biggest frame act as the biggest frame
    assign lim_in = (limit > LIM_MAX) ? LIM_MAX : limit;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= S_IDLE;
            count <= '0;
            lim   <= '0;
        end
        else if (!st)
        begin
            state <= S_IDLE;
            count <= '0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    // first cycle with st high, take the switches
                    state <= S_PLAY;
                    lim   <= lim_in;
                    count <= '0;
                end
                S_PLAY:
                begin
                    if (pump)
                    begin
                        if (count == lim)
                            state <= S_BURST; // one past the limit
                        else
                            count <= count + 3'd1;
                    end
                    else if (bank && (count != 3'd0))
                    begin
                        state <= S_WON;
                    end
                end
                S_BURST, S_WON:
                begin
                    state <= state; // round over, wait for st to drop
                end
                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    always_comb
    begin
        view.run  = (state != S_IDLE);
        view.warn = (state == S_PLAY) && (count == lim);
        case (state)
            S_PLAY:
            begin
                view.frame = dotmatrix_pkg::frame_id_t'(count);
            end
            S_BURST:
            begin
                view.frame = dotmatrix_pkg::FRAME_BURST;
            end
            S_WON:
            begin
                view.frame = dotmatrix_pkg::FRAME_TROPHY;
            end
            default:
            begin
                view.frame = dotmatrix_pkg::FRAME_BALLOON_0;
            end
        endcase
    end

endmodule

// File: logic/frame_rom.sv
`timescale 1ns/1ps

module frame_rom (
    input  dotmatrix_pkg::frame_id_t   frame,
    input  dotmatrix_pkg::row_idx_t    row_idx,
    output dotmatrix_pkg::row_pixels_t pixels
);

    always_comb
    begin
        pixels = '0;
        case (frame)
            dotmatrix_pkg::FRAME_BALLOON_0:
            begin
                case (row_idx)
                    3'd2, 3'd5: pixels.green = 8'b0001_1000;
                    3'd3, 3'd4: pixels.green = 8'b0011_1100;
                    default:    pixels.green = 8'b0000_0000;
                endcase
            end
            dotmatrix_pkg::FRAME_BALLOON_1:
            begin
                case (row_idx)
                    3'd2, 3'd5: pixels.green = 8'b0011_1000;
                    3'd3, 3'd4: pixels.green = 8'b0111_1100;
                    default:    pixels.green = 8'b0000_0000;
                endcase
            end
            dotmatrix_pkg::FRAME_BALLOON_2:
            begin
                case (row_idx)
                    3'd2, 3'd5: pixels.green = 8'b0011_1100;
                    3'd3, 3'd4: pixels.green = 8'b0111_1110;
                    default:    pixels.green = 8'b0000_0000;
                endcase
            end
            dotmatrix_pkg::FRAME_BALLOON_3:
            begin
                case (row_idx)
                    3'd1, 3'd6:             pixels.green = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5: pixels.green = 8'b0111_1110;
                    default:                pixels.green = 8'b0000_0000;
                endcase
            end
            dotmatrix_pkg::FRAME_BALLOON_4:
            begin
                case (row_idx)
                    3'd0, 3'd7: pixels.green = 8'b0011_1100;
                    3'd1, 3'd6: pixels.green = 8'b0111_1110;
                    default:    pixels.green = 8'b1111_1111;
                endcase
            end
            dotmatrix_pkg::FRAME_BALLOON_5:
            begin
                // nearly fills the panel
                case (row_idx)
                    3'd0, 3'd7: pixels.green = 8'b0111_1110;
                    default:    pixels.green = 8'b1111_1111;
                endcase
            end
            dotmatrix_pkg::FRAME_BURST:
            begin
                case (row_idx)
                    3'd1:    pixels.red = 8'b0011_1000;
                    3'd2:    pixels.red = 8'b0100_0100;
                    3'd3:    pixels.red = 8'b0101_1010;
                    3'd4:    pixels.red = 8'b0100_1010;
                    3'd5:    pixels.red = 8'b0011_0010;
                    3'd6:    pixels.red = 8'b1100_0100;
                    3'd7:    pixels.red = 8'b0011_1000;
                    default: pixels.red = 8'b0000_0000;
                endcase
            end
            dotmatrix_pkg::FRAME_TROPHY:
            begin
                case (row_idx)
                    3'd0:    pixels.red = 8'b1110_0000;
                    3'd1:    pixels.red = 8'b0110_0000;
                    3'd2:    pixels.red = 8'b1110_0000;
                    3'd3:    pixels.red = 8'b0011_0000;
                    3'd4:    pixels.red = 8'b0011_0001;
                    3'd5:    pixels.red = 8'b0011_0011;
                    3'd6:    pixels.red = 8'b0011_1110;
                    default: pixels.red = 8'b0001_1100;
                endcase
            end
            default:
            begin
                pixels = '0; // unused frame numbers are blank
            end
        endcase
    end

endmodule

// File: logic/matrix_scanner.sv
`timescale 1ns/1ps

module matrix_scanner (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        step_tick,
    input  dotmatrix_pkg::game_view_t   view,
    input  dotmatrix_pkg::row_pixels_t  pixels,
    output dotmatrix_pkg::row_idx_t     row_idx,
    output dotmatrix_pkg::pixel_byte_t  row,
    output dotmatrix_pkg::pixel_byte_t  colr,
    output dotmatrix_pkg::pixel_byte_t  colg
);

    localparam dotmatrix_pkg::frame_id_t LAST_BALLOON =
        dotmatrix_pkg::frame_id_t'(dotmatrix_pkg::MAX_PUMPS);

    logic                       is_balloon;
    logic                       is_red_only;
    dotmatrix_pkg::pixel_byte_t row_n;
    dotmatrix_pkg::pixel_byte_t colr_n;
    dotmatrix_pkg::pixel_byte_t colg_n;

    assign is_balloon  = (view.frame <= LAST_BALLOON);
    assign is_red_only = (view.frame == dotmatrix_pkg::FRAME_BURST) ||
                         (view.frame == dotmatrix_pkg::FRAME_TROPHY);

    // colour rule on the raw bitmap bytes
    always_comb
    begin
        row_n  = 8'hff;
        colr_n = '0;
        colg_n = '0;
        if (view.run)
        begin
            row_n = ~(8'b0000_0001 << row_idx); // active low, one row lit
            if (is_balloon)
            begin
                colg_n = pixels.green;
                // yellow normally, green alone at the limit
                colr_n = view.warn ? 8'h00 : pixels.green;
            end
            else if (is_red_only)
            begin
                colr_n = pixels.red;
            end
        end
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_idx <= '0;
        end
        else if (step_tick)
        begin
            row_idx <= row_idx + 3'd1; // wraps 7 to 0
        end
    end

    // view and row are captured into the drive registers every cycle
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= 8'hff;
            colr <= '0;
            colg <= '0;
        end
        else
        begin
            row  <= row_n;
            colr <= colr_n;
            colg <= colg_n;
        end
    end

endmodule

// File: logic/balloon_top.sv
`timescale 1ns/1ps

module balloon_top #(
    parameter int unsigned SCAN_DIV = 1000  // 1 MHz clk to 1 kHz row rate
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       st,
    input  logic                       pump,
    input  logic                       bank,
    input  logic [2:0]                 limit,
    output dotmatrix_pkg::pixel_byte_t row,
    output dotmatrix_pkg::pixel_byte_t colr,
    output dotmatrix_pkg::pixel_byte_t colg
);

    logic                        step_tick;
    dotmatrix_pkg::game_view_t   view;
    dotmatrix_pkg::row_idx_t     row_idx;
    dotmatrix_pkg::row_pixels_t  pixels;

    scan_timer #(
        .SCAN_DIV (SCAN_DIV)
    ) u_scan_timer (
        .clk       (clk),
        .rst       (rst),
        .step_tick (step_tick)
    );

    balloon_game u_balloon_game (
        .clk   (clk),
        .rst   (rst),
        .st    (st),
        .pump  (pump),
        .bank  (bank),
        .limit (limit),
        .view  (view)
    );

    frame_rom u_frame_rom (
        .frame   (view.frame),
        .row_idx (row_idx),
        .pixels  (pixels)
    );

    matrix_scanner u_matrix_scanner (
        .clk       (clk),
        .rst       (rst),
        .step_tick (step_tick),
        .view      (view),
        .pixels    (pixels),
        .row_idx   (row_idx),
        .row       (row),
        .colr      (colr),
        .colg      (colg)
    );

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial
    begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0; // release just after the edge
    end

endmodule

// File: bench/balloon_tb.sv
`timescale 1ns/1ps

module balloon_tb;

    localparam int unsigned PERIOD_NS    = 4;
    localparam int unsigned RESET_CYCLES = 16;
    localparam int unsigned SCAN_DIV     = 4;
    localparam int unsigned NUM_TESTS    = 14;
    localparam int unsigned FRAME_CYCLES = 8 * SCAN_DIV;

    // blank check, start, up to 15 pumps with widest gaps, bank, settle, 8 samples
    localparam int unsigned TEST_CYCLES =
        8 + 2 + 15 * 4 + 4 + 2 * FRAME_CYCLES + 8 * 3 * SCAN_DIV;
    localparam int unsigned WATCHDOG_NS =
        PERIOD_NS * (RESET_CYCLES + 4 + NUM_TESTS * TEST_CYCLES);

    typedef struct packed
    {
        logic [2:0]               limit;
        logic [3:0]               pumps;
        logic                     bank;
        dotmatrix_pkg::frame_id_t frame; // expected picture
        logic                     warn;  // expected warning level
    } test_vec_t;

    logic                       clk;
    logic                       rst;
    logic                       st;
    logic                       pump;
    logic                       bank;
    logic [2:0]                 limit;
    dotmatrix_pkg::pixel_byte_t row;
    dotmatrix_pkg::pixel_byte_t colr;
    dotmatrix_pkg::pixel_byte_t colg;

    test_vec_t   vectors [NUM_TESTS];
    logic [31:0] lfsr_state;
    int          errors;
    int          failed_tests;

    tb_clock #(
        .PERIOD_NS    (PERIOD_NS),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock (
        .clk (clk),
        .rst (rst)
    );

    balloon_top #(
        .SCAN_DIV (SCAN_DIV)
    ) DUT (
        .clk   (clk),
        .rst   (rst),
        .st    (st),
        .pump  (pump),
        .bank  (bank),
        .limit (limit),
        .row   (row),
        .colr  (colr),
        .colg  (colg)
    );

    // row 0 in the top byte with bit 7 leftmost
    function automatic logic [63:0] bitmap_word(input dotmatrix_pkg::frame_id_t frame);
        case (frame)
            dotmatrix_pkg::FRAME_BALLOON_0: return 64'h0000_183c_3c18_0000;
            dotmatrix_pkg::FRAME_BALLOON_1: return 64'h0000_387c_7c38_0000;
            dotmatrix_pkg::FRAME_BALLOON_2: return 64'h0000_3c7e_7e3c_0000;
            dotmatrix_pkg::FRAME_BALLOON_3: return 64'h003c_7e7e_7e7e_3c00;
            dotmatrix_pkg::FRAME_BALLOON_4: return 64'h3c7e_ffff_ffff_7e3c;
            dotmatrix_pkg::FRAME_BALLOON_5: return 64'h7eff_ffff_ffff_ff7e;
            dotmatrix_pkg::FRAME_BURST:     return 64'h0038_445a_4a32_c438;
            dotmatrix_pkg::FRAME_TROPHY:    return 64'he060_e030_3133_3e1c;
            default:                        return 64'h0;
        endcase
    endfunction

    function automatic dotmatrix_pkg::row_pixels_t expected_drive(input test_vec_t tv,
                                                                  input int unsigned r);
        logic [63:0]                 word;
        dotmatrix_pkg::pixel_byte_t  bits;
        dotmatrix_pkg::row_pixels_t  drive;
        word  = bitmap_word(tv.frame);
        bits  = word[63 - 8 * r -: 8];
        drive = '0;
        if (tv.frame <= dotmatrix_pkg::FRAME_BALLOON_5)
        begin
            drive.green = bits;
            drive.red   = tv.warn ? 8'h00 : bits; // yellow unless at the limit
        end
        else if (tv.frame == dotmatrix_pkg::FRAME_BURST ||
                 tv.frame == dotmatrix_pkg::FRAME_TROPHY)
        begin
            drive.red = bits;
        end
        return drive;
    endfunction

    // galois lfsr stepped once per bit taken
    function automatic int unsigned draw_bits(input int unsigned n);
        int unsigned val;
        val = 0;
        for (int unsigned i = 0; i < n; i++)
        begin
            val = (val << 1) | {31'd0, lfsr_state[0]};
            if (lfsr_state[0])
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
            else
                lfsr_state = lfsr_state >> 1;
        end
        return val;
    endfunction

    task automatic after_edge();
        @(posedge clk);
        #1;
    endtask

    task automatic check_blank(input int unsigned cycles);
        repeat (cycles)
        begin
            @(negedge clk);
            assert (row == 8'hff && colr == 8'h00 && colg == 8'h00)
            else
            begin
                $display("ERR %0t: display not blank, row %h colr %h colg %h",
                         $time, row, colr, colg);
                errors++;
            end
        end
    endtask

    task automatic sample_rows(input test_vec_t tv);
        dotmatrix_pkg::pixel_byte_t last_row;
        dotmatrix_pkg::row_pixels_t exp;
        int unsigned                waited;
        int unsigned                idx;
        int unsigned                prev_idx;
        prev_idx = 0;
        for (int unsigned s = 0; s < 8; s++)
        begin
            // line up on the next row change, then move to mid period
            @(negedge clk);
            last_row = row;
            waited   = 0;
            while (row == last_row && waited < 2 * SCAN_DIV)
            begin
                @(negedge clk);
                waited++;
            end
            assert (row != last_row)
            else
            begin
                $display("row scan stalled at %0t, no new row within %0d cycles",
                         $time, 2 * SCAN_DIV);
                errors++;
            end
            if (row == last_row)
                return;
            repeat (SCAN_DIV / 2 - 1) @(negedge clk);

            assert ($onehot(~row))
            else
            begin
                $display("ERR %0t: row %h is not active-low one-hot", $time, row);
                errors++;
            end
            idx = 0;
            for (int unsigned b = 0; b < 8; b++)
            begin
                if (!row[b])
                    idx = b;
            end
            if (s > 0)
            begin
                assert (idx == (prev_idx + 1) % 8)
                else
                begin
                    $display("ERR %0t: row %0d follows row %0d", $time, idx, prev_idx);
                    errors++;
                end
            end
            prev_idx = idx;

            exp = expected_drive(tv, idx);
            assert (colr == exp.red && colg == exp.green)
            else
            begin
                $display("ERR %0t: row %0d colr %h colg %h, expected colr %h colg %h",
                         $time, idx, colr, colg, exp.red, exp.green);
                errors++;
            end
        end
    endtask

    task automatic run_test(input int unsigned n, input test_vec_t tv);
        int unsigned gap;
        int          start_errors;
        start_errors = errors;

        after_edge();
        st    = 1'b0;
        limit = tv.limit;
        repeat (2) @(negedge clk); // game to idle, then drive registers
        check_blank(6);

        after_edge();
        st = 1'b1;
        after_edge(); // limit taken here
        for (int p = 0; p < int'(tv.pumps); p++)
        begin
            pump = 1'b1;
            after_edge();
            pump = 1'b0;
            gap = draw_bits(2);
            repeat (gap) after_edge();
        end
        if (tv.bank)
        begin
            bank = 1'b1;
            after_edge();
            bank = 1'b0;
        end

        repeat (2 * FRAME_CYCLES) @(posedge clk);
        sample_rows(tv);

        if (errors == start_errors)
        begin
            $display("test %0d: limit %0d pumps %0d bank %0d -> frame %0d warn %0d ok",
                     n, tv.limit, tv.pumps, tv.bank, tv.frame, tv.warn);
        end
        else
        begin
            failed_tests++;
            $display("test %0d: limit %0d pumps %0d bank %0d failed with %0d errors",
                     n, tv.limit, tv.pumps, tv.bank, errors - start_errors);
        end
    endtask

    task automatic load_vectors();
        vectors[0]  = '{3'd3, 4'd0, 1'b0, dotmatrix_pkg::FRAME_BALLOON_0, 1'b0};
        vectors[1]  = '{3'd3, 4'd2, 1'b0, dotmatrix_pkg::FRAME_BALLOON_2, 1'b0};
        vectors[2]  = '{3'd3, 4'd3, 1'b0, dotmatrix_pkg::FRAME_BALLOON_3, 1'b1};
        vectors[3]  = '{3'd5, 4'd4, 1'b0, dotmatrix_pkg::FRAME_BALLOON_4, 1'b0};
        vectors[4]  = '{3'd7, 4'd5, 1'b0, dotmatrix_pkg::FRAME_BALLOON_5, 1'b1}; // clamped
        vectors[5]  = '{3'd6, 4'd6, 1'b0, dotmatrix_pkg::FRAME_BURST, 1'b0};
        vectors[6]  = '{3'd2, 4'd3, 1'b0, dotmatrix_pkg::FRAME_BURST, 1'b0};
        vectors[7]  = '{3'd2, 4'd5, 1'b1, dotmatrix_pkg::FRAME_BURST, 1'b0};
        vectors[8]  = '{3'd4, 4'd2, 1'b1, dotmatrix_pkg::FRAME_TROPHY, 1'b0};
        vectors[9]  = '{3'd3, 4'd0, 1'b1, dotmatrix_pkg::FRAME_BALLOON_0, 1'b0};
        vectors[10] = '{3'd0, 4'd0, 1'b0, dotmatrix_pkg::FRAME_BALLOON_0, 1'b1};
        vectors[11] = '{3'd0, 4'd1, 1'b1, dotmatrix_pkg::FRAME_BURST, 1'b0};
        vectors[12] = '{3'd1, 4'd1, 1'b1, dotmatrix_pkg::FRAME_TROPHY, 1'b0};
        vectors[13] = '{3'd5, 4'd1, 1'b0, dotmatrix_pkg::FRAME_BALLOON_1, 1'b0};
    endtask

    initial
    begin
        st           = 1'b0;
        pump         = 1'b0;
        bank         = 1'b0;
        limit        = 3'd0;
        errors       = 0;
        failed_tests = 0;
        lfsr_state   = 32'haca1_241a;
        load_vectors();

        check_blank(12); // still in reset
        wait (rst == 1'b0);
        check_blank(4);

        for (int unsigned t = 0; t < NUM_TESTS; t++)
            run_test(t, vectors[t]);

        $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, failed_tests, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: project.f
logic/dotmatrix_pkg.sv
logic/scan_timer.sv
logic/balloon_game.sv
logic/frame_rom.sv
logic/matrix_scanner.sv
logic/balloon_top.sv
bench/tb_clock.sv
bench/balloon_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = balloon_tb
RTL_TOP   = balloon_top
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
